/* logic/forth_pkg.sv */
/*
 * Forth processor shared definitions
 * Cell and address widths, stack and queue sizes, serial timing,
 * opcodes and the execution token addresses of the boot ROM
 */
package forth_pkg;

	// Cell and boot ROM sizes
	localparam int cell_width = 32;
	localparam int rom_addr_width = 7;

	// Circular data stack
	localparam int stack_depth = 16;
	localparam int stack_ptr_width = $clog2(stack_depth);

	// Token queue, one credit per entry
	localparam int queue_depth = 4;
	localparam int queue_ptr_width = $clog2(queue_depth);
	localparam int credit_width = $clog2(queue_depth + 1);
	localparam logic [credit_width-1:0] credit_init = credit_width'(queue_depth);

	// Serial bit time, shortened for simulation
	localparam int uart_clks_per_bit = 16;
	localparam int uart_cnt_width = $clog2(uart_clks_per_bit);
	localparam logic [uart_cnt_width-1:0] uart_mid_count =
		uart_cnt_width'(uart_clks_per_bit / 2 - 1);
	localparam logic [uart_cnt_width-1:0] uart_last_count =
		uart_cnt_width'(uart_clks_per_bit - 1);

	// Dictionary walk, entry is link, length, two name cells, token
	localparam int dict_ptr_width = 3;
	localparam logic [dict_ptr_width-1:0] dict_head = 3'd6;
	localparam int dict_entry_width = dict_ptr_width + 4 + 2 * cell_width + rom_addr_width;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes, one ROM word each
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [cell_width-1:0] {
		op_execute,
		op_lit,
		op_emit,
		op_branch,
		op_zero_branch,
		op_plus,
		op_minus,
		op_dup,
		op_zero_less,
		op_negate,
		op_drop,
		op_io_led,
		op_number
	} op_e;

	// Routine entry points in the boot ROM
	localparam logic [rom_addr_width-1:0] xt_error = 7'd1;
	localparam logic [rom_addr_width-1:0] xt_red = 7'd6;
	localparam logic [rom_addr_width-1:0] xt_green = 7'd11;
	localparam logic [rom_addr_width-1:0] xt_blue = 7'd16;
	localparam logic [rom_addr_width-1:0] xt_number = 7'd21;
	localparam logic [rom_addr_width-1:0] xt_dot = 7'd24;
	localparam logic [rom_addr_width-1:0] xt_plus = 7'd41;
	localparam logic [rom_addr_width-1:0] xt_minus = 7'd44;

endpackage

/* logic/uart_rx.sv */
/*
 * Serial receiver
 * Finds the start edge, samples each bit at its middle and holds the
 * byte until taken. A frame ending while the byte is unread is lost
 */
`timescale 1ns/1ns

module uart_rx (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	input  logic rx_take,
	output logic [7:0] rx_byte,
	output logic rx_valid
);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_frame} rx_state_e;

	rx_state_e state;
	logic [1:0] rx_sync;
	logic [forth_pkg::uart_cnt_width-1:0] clk_cnt;
	logic [3:0] bit_cnt;
	// Eight data bits then the stop bit
	logic [8:0] shift;
	logic mid_bit;
	logic end_bit;

	assign mid_bit = clk_cnt == forth_pkg::uart_mid_count;
	assign end_bit = clk_cnt == forth_pkg::uart_last_count;

	always_ff @(posedge clk) begin
		if (!reset) begin
			// Line idles high
			rx_sync <= 2'b11;
			state <= rx_idle;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			if (rx_take)
				rx_valid <= 1'b0;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					if (!rx_sync[1])
						state <= rx_start;
				end
				rx_start: begin
					clk_cnt <= clk_cnt + 1'b1;
					// Glitch, line back high at mid bit
					if (mid_bit && rx_sync[1])
						state <= rx_idle;
					else if (end_bit)
						state <= rx_frame;
				end
				default: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (end_bit) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 4'd8) begin
							state <= rx_idle;
							// Good stop bit and nothing held
							if (shift[8] && !rx_valid)
								rx_valid <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	// Sample register and held byte
	always_ff @(posedge clk) begin
		if (state == rx_frame && mid_bit)
			shift <= {rx_sync[1], shift[8:1]};
		if (state == rx_frame && end_bit && bit_cnt == 4'd8 && shift[8] && !rx_valid)
			rx_byte <= shift[7:0];
	end

endmodule

/* logic/uart_tx.sv */
/*
 * Serial transmitter
 * Sends one byte per request as start bit, eight data bits LSB first
 * and stop bit, busy until the stop bit has ended
 */
`timescale 1ns/1ns

module uart_tx (
	input  logic clk,
	input  logic reset,
	input  logic tx_start,
	input  logic [7:0] tx_byte,
	output logic tx,
	output logic tx_busy
);

	// Frame shifts out from bit 0, ones shift in behind it
	logic [9:0] shift;
	logic [3:0] bit_cnt;
	logic [forth_pkg::uart_cnt_width-1:0] clk_cnt;

	assign tx = shift[0];

	always_ff @(posedge clk) begin
		if (!reset) begin
			shift <= '1;
			bit_cnt <= '0;
			clk_cnt <= '0;
			tx_busy <= 1'b0;
		end else if (!tx_busy) begin
			clk_cnt <= '0;
			bit_cnt <= '0;
			if (tx_start) begin
				shift <= {1'b1, tx_byte, 1'b0};
				tx_busy <= 1'b1;
			end
		end else if (clk_cnt == forth_pkg::uart_last_count) begin
			// Next bit
			clk_cnt <= '0;
			shift <= {1'b1, shift[9:1]};
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == 4'd9)
				tx_busy <= 1'b0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

/* logic/outer_interp.sv */
/*
 * Outer interpreter
 * Gathers characters into blank separated words, walks the linked
 * dictionary and issues one token per word while credits remain
 */
`timescale 1ns/1ns

module outer_interp (
	input  logic clk,
	input  logic reset,
	input  logic [7:0] rx_byte,
	input  logic rx_valid,
	output logic rx_take,
	output logic tok_push,
	output logic [forth_pkg::rom_addr_width-1:0] tok_xt,
	output logic [3:0] tok_value,
	input  logic tok_credit
);

	typedef enum logic [2:0] {idle, gather, search, issue, skip} state_e;

	state_e state;
	logic [7:0] char_q;
	// Name right justified, newest character in the low byte
	logic [1:0][forth_pkg::cell_width-1:0] name;
	logic [3:0] len;
	logic [forth_pkg::dict_ptr_width-1:0] ptr;
	logic [forth_pkg::credit_width-1:0] credits;
	logic [forth_pkg::rom_addr_width-1:0] xt_q;
	logic [3:0] value_q;
	logic is_digit;

	// Entry under the pointer
	logic [forth_pkg::dict_entry_width-1:0] entry;
	logic [forth_pkg::dict_ptr_width-1:0] ent_link;
	logic [3:0] ent_len;
	logic [1:0][forth_pkg::cell_width-1:0] ent_name;
	logic [forth_pkg::rom_addr_width-1:0] ent_xt;

	function automatic logic delim(input logic [7:0] c);
		return c == " " || c == 8'h0d || c == 8'h0a;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Dictionary, newest first, link 0 ends the list
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (ptr)
			3'd6: entry = {3'd5, 4'd1, 64'("-"), forth_pkg::xt_minus};
			3'd5: entry = {3'd4, 4'd1, 64'("+"), forth_pkg::xt_plus};
			3'd4: entry = {3'd3, 4'd1, 64'("."), forth_pkg::xt_dot};
			3'd3: entry = {3'd2, 4'd4, 64'("blue"), forth_pkg::xt_blue};
			3'd2: entry = {3'd1, 4'd5, 64'("green"), forth_pkg::xt_green};
			3'd1: entry = {3'd0, 4'd3, 64'("red"), forth_pkg::xt_red};
			default: entry = '0;
		endcase
	end

	assign {ent_link, ent_len, ent_name, ent_xt} = entry;

	// Single digit words become number tokens
	assign is_digit = len == 4'd1 && name[0][7:0] >= "0" && name[0][7:0] <= "9";

	assign rx_take = rx_valid && (state == idle || state == skip);
	assign tok_push = state == issue && credits != '0;
	assign tok_xt = xt_q;
	assign tok_value = value_q;

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= idle;
			name <= '0;
			len <= '0;
			ptr <= '0;
			credits <= forth_pkg::credit_init;
		end else begin
			// One credit spent per push, one back per token taken
			if (tok_push && !tok_credit)
				credits <= credits - 1'b1;
			else if (!tok_push && tok_credit)
				credits <= credits + 1'b1;
			case (state)
				idle: begin
					if (rx_valid)
						state <= gather;
				end
				gather: begin
					if (delim(char_q)) begin
						ptr <= forth_pkg::dict_head;
						// Empty word issues nothing
						state <= (len != '0) ? search : idle;
					end else if (len == 4'd8) begin
						state <= skip;
					end else begin
						name <= {name[1][23:0], name[0], char_q};
						len <= len + 1'b1;
						state <= idle;
					end
				end
				search: begin
					if (ent_len == len && ent_name == name)
						state <= issue;
					else if (ent_link == '0)
						state <= issue;
					else
						ptr <= ent_link;
				end
				skip: begin
					// Overlong word, drop the rest
					if (rx_valid && delim(rx_byte))
						state <= issue;
				end
				default: begin
					// Hold here under back pressure
					if (credits != '0) begin
						name <= '0;
						len <= '0;
						state <= idle;
					end
				end
			endcase
		end
	end

	// Character and token payload
	always_ff @(posedge clk) begin
		if (state == idle && rx_valid)
			char_q <= rx_byte;
		if (state == skip)
			xt_q <= forth_pkg::xt_error;
		if (state == search) begin
			if (ent_len == len && ent_name == name) begin
				xt_q <= ent_xt;
			end else if (ent_link == '0) begin
				xt_q <= is_digit ? forth_pkg::xt_number : forth_pkg::xt_error;
				// Low nibble of an ASCII digit is its value
				value_q <= name[0][3:0];
			end
		end
	end

endmodule

/* logic/token_queue.sv */
/*
 * Token queue
 * FIFO between the two interpreters, returns one credit to the
 * outer interpreter for every token the inner interpreter takes
 */
`timescale 1ns/1ns

module token_queue (
	input  logic clk,
	input  logic reset,
	input  logic tok_push,
	input  logic [forth_pkg::rom_addr_width-1:0] tok_xt,
	input  logic [3:0] tok_value,
	input  logic q_pop,
	output logic q_valid,
	output logic [forth_pkg::rom_addr_width-1:0] q_xt,
	output logic [3:0] q_value,
	output logic tok_credit
);

	// Token address and digit value per entry
	logic [forth_pkg::rom_addr_width+3:0] mem [forth_pkg::queue_depth];
	logic [forth_pkg::queue_ptr_width-1:0] wr_ptr;
	logic [forth_pkg::queue_ptr_width-1:0] rd_ptr;
	logic [forth_pkg::credit_width-1:0] count;

	assign q_valid = count != '0;
	assign {q_xt, q_value} = mem[rd_ptr];
	assign tok_credit = q_pop && q_valid;

	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Credits keep pushes within the depth
			if (tok_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (tok_credit)
				rd_ptr <= rd_ptr + 1'b1;
			if (tok_push && !tok_credit)
				count <= count + 1'b1;
			else if (!tok_push && tok_credit)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (tok_push)
			mem[wr_ptr] <= {tok_xt, tok_value};
	end

endmodule

/* logic/data_stack.sv */
/*
 * Data stack
 * Circular stack of cells with top and next readout, push, pop,
 * top replace, and pop with replace for binary operators
 */
`timescale 1ns/1ns

module data_stack (
	input  logic clk,
	input  logic reset,
	input  logic st_push,
	input  logic st_pop,
	input  logic st_write,
	input  logic [forth_pkg::cell_width-1:0] st_data,
	output logic [forth_pkg::cell_width-1:0] st_top,
	output logic [forth_pkg::cell_width-1:0] st_next,
	output logic [forth_pkg::stack_ptr_width:0] st_depth
);

	logic [forth_pkg::cell_width-1:0] mem [forth_pkg::stack_depth];
	// Points at the top entry, wraps around
	logic [forth_pkg::stack_ptr_width-1:0] sp;

	assign st_top = mem[sp];
	assign st_next = mem[sp - 1'b1];

	always_ff @(posedge clk) begin
		if (!reset) begin
			sp <= '0;
			st_depth <= '0;
		end else if (st_push) begin
			sp <= sp + 1'b1;
			st_depth <= st_depth + 1'b1;
		end else if (st_pop) begin
			sp <= sp - 1'b1;
			st_depth <= st_depth - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (st_push)
			mem[sp + 1'b1] <= st_data;
		else if (st_pop && st_write)
			// Result replaces next, top drops
			mem[sp - 1'b1] <= st_data;
		else if (st_write)
			mem[sp] <= st_data;
	end

endmodule

/* logic/inner_interp.sv */
/*
 * Inner interpreter
 * Boot ROM with fetch and execute of one opcode per cycle, waits at
 * address 0 for a token, drives the LEDs and the emit request
 */
`timescale 1ns/1ns

module inner_interp (
	input  logic clk,
	input  logic reset,
	input  logic q_valid,
	input  logic [forth_pkg::rom_addr_width-1:0] q_xt,
	input  logic [3:0] q_value,
	output logic q_pop,
	output logic st_push,
	output logic st_pop,
	output logic st_write,
	output logic [forth_pkg::cell_width-1:0] st_data,
	input  logic [forth_pkg::cell_width-1:0] st_top,
	input  logic [forth_pkg::cell_width-1:0] st_next,
	output logic tx_start,
	output logic [7:0] tx_byte,
	input  logic tx_busy,
	output logic led_r,
	output logic led_g,
	output logic led_b
);

	logic [forth_pkg::rom_addr_width-1:0] pc;
	logic [forth_pkg::rom_addr_width-1:0] pc_next;
	forth_pkg::op_e op;
	logic [forth_pkg::cell_width-1:0] operand;
	// Digit saved with the token
	logic [3:0] value_q;

	////////////////////////////////////////////////////////////////////////////
	// Boot ROM, every routine branches back to 0
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [forth_pkg::cell_width-1:0] rom_word(
		input logic [forth_pkg::rom_addr_width-1:0] addr);
		case (addr)
			7'd0: rom_word = forth_pkg::op_execute;
			// Unknown word
			forth_pkg::xt_error: rom_word = forth_pkg::op_lit;
			forth_pkg::xt_error + 7'd1: rom_word = {24'd0, "?"};
			forth_pkg::xt_error + 7'd2: rom_word = forth_pkg::op_emit;
			forth_pkg::xt_error + 7'd3: rom_word = forth_pkg::op_branch;
			forth_pkg::xt_error + 7'd4: rom_word = 32'd0;
			// LED words, bit 2 red, bit 1 blue, bit 0 green
			forth_pkg::xt_red: rom_word = forth_pkg::op_lit;
			forth_pkg::xt_red + 7'd1: rom_word = 32'd4;
			forth_pkg::xt_red + 7'd2: rom_word = forth_pkg::op_io_led;
			forth_pkg::xt_red + 7'd3: rom_word = forth_pkg::op_branch;
			forth_pkg::xt_red + 7'd4: rom_word = 32'd0;
			forth_pkg::xt_green: rom_word = forth_pkg::op_lit;
			forth_pkg::xt_green + 7'd1: rom_word = 32'd1;
			forth_pkg::xt_green + 7'd2: rom_word = forth_pkg::op_io_led;
			forth_pkg::xt_green + 7'd3: rom_word = forth_pkg::op_branch;
			forth_pkg::xt_green + 7'd4: rom_word = 32'd0;
			forth_pkg::xt_blue: rom_word = forth_pkg::op_lit;
			forth_pkg::xt_blue + 7'd1: rom_word = 32'd2;
			forth_pkg::xt_blue + 7'd2: rom_word = forth_pkg::op_io_led;
			forth_pkg::xt_blue + 7'd3: rom_word = forth_pkg::op_branch;
			forth_pkg::xt_blue + 7'd4: rom_word = 32'd0;
			// Digit literal
			forth_pkg::xt_number: rom_word = forth_pkg::op_number;
			forth_pkg::xt_number + 7'd1: rom_word = forth_pkg::op_branch;
			forth_pkg::xt_number + 7'd2: rom_word = 32'd0;
			// Dot, sign then digit then blank
			forth_pkg::xt_dot: rom_word = forth_pkg::op_dup;
			forth_pkg::xt_dot + 7'd1: rom_word = forth_pkg::op_zero_less;
			forth_pkg::xt_dot + 7'd2: rom_word = forth_pkg::op_zero_branch;
			forth_pkg::xt_dot + 7'd3: rom_word = {25'd0, forth_pkg::xt_dot + 7'd8};
			forth_pkg::xt_dot + 7'd4: rom_word = forth_pkg::op_lit;
			forth_pkg::xt_dot + 7'd5: rom_word = {24'd0, "-"};
			forth_pkg::xt_dot + 7'd6: rom_word = forth_pkg::op_emit;
			forth_pkg::xt_dot + 7'd7: rom_word = forth_pkg::op_negate;
			forth_pkg::xt_dot + 7'd8: rom_word = forth_pkg::op_lit;
			forth_pkg::xt_dot + 7'd9: rom_word = {24'd0, "0"};
			forth_pkg::xt_dot + 7'd10: rom_word = forth_pkg::op_plus;
			forth_pkg::xt_dot + 7'd11: rom_word = forth_pkg::op_emit;
			forth_pkg::xt_dot + 7'd12: rom_word = forth_pkg::op_lit;
			forth_pkg::xt_dot + 7'd13: rom_word = {24'd0, " "};
			forth_pkg::xt_dot + 7'd14: rom_word = forth_pkg::op_emit;
			forth_pkg::xt_dot + 7'd15: rom_word = forth_pkg::op_branch;
			forth_pkg::xt_dot + 7'd16: rom_word = 32'd0;
			// Arithmetic
			forth_pkg::xt_plus: rom_word = forth_pkg::op_plus;
			forth_pkg::xt_plus + 7'd1: rom_word = forth_pkg::op_branch;
			forth_pkg::xt_plus + 7'd2: rom_word = 32'd0;
			forth_pkg::xt_minus: rom_word = forth_pkg::op_minus;
			forth_pkg::xt_minus + 7'd1: rom_word = forth_pkg::op_branch;
			forth_pkg::xt_minus + 7'd2: rom_word = 32'd0;
			// Unused words wait for a token
			default: rom_word = 32'd0;
		endcase
	endfunction

	assign op = forth_pkg::op_e'(rom_word(pc));
	assign operand = rom_word(pc + 7'd1);
	assign tx_byte = st_top[7:0];

	// Decode and stack control
	always_comb begin
		pc_next = pc + 7'd1;
		q_pop = 1'b0;
		st_push = 1'b0;
		st_pop = 1'b0;
		st_write = 1'b0;
		st_data = st_top;
		tx_start = 1'b0;
		case (op)
			forth_pkg::op_execute: begin
				pc_next = pc;
				if (q_valid) begin
					q_pop = 1'b1;
					pc_next = q_xt;
				end
			end
			forth_pkg::op_lit: begin
				st_push = 1'b1;
				st_data = operand;
				pc_next = pc + 7'd2;
			end
			forth_pkg::op_emit: begin
				// Stall while a frame is on the line
				if (tx_busy) begin
					pc_next = pc;
				end else begin
					tx_start = 1'b1;
					st_pop = 1'b1;
				end
			end
			forth_pkg::op_branch: pc_next = operand[forth_pkg::rom_addr_width-1:0];
			forth_pkg::op_zero_branch: begin
				st_pop = 1'b1;
				if (st_top == '0)
					pc_next = operand[forth_pkg::rom_addr_width-1:0];
				else
					pc_next = pc + 7'd2;
			end
			forth_pkg::op_plus: begin
				st_pop = 1'b1;
				st_write = 1'b1;
				st_data = st_next + st_top;
			end
			forth_pkg::op_minus: begin
				st_pop = 1'b1;
				st_write = 1'b1;
				st_data = st_next - st_top;
			end
			forth_pkg::op_dup: st_push = 1'b1;
			forth_pkg::op_zero_less: begin
				st_write = 1'b1;
				st_data = {forth_pkg::cell_width{st_top[forth_pkg::cell_width-1]}};
			end
			forth_pkg::op_negate: begin
				st_write = 1'b1;
				st_data = -st_top;
			end
			forth_pkg::op_drop: st_pop = 1'b1;
			forth_pkg::op_io_led: st_pop = 1'b1;
			forth_pkg::op_number: begin
				st_push = 1'b1;
				st_data = {{(forth_pkg::cell_width - 4){1'b0}}, value_q};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			led_r <= 1'b1;
			led_g <= 1'b1;
			led_b <= 1'b1;
		end else begin
			pc <= pc_next;
			// LEDs are active low
			if (op == forth_pkg::op_io_led) begin
				led_g <= ~st_top[0];
				led_b <= ~st_top[1];
				led_r <= ~st_top[2];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (q_pop)
			value_q <= q_value;
	end

endmodule

/* logic/forth_core.sv */
/*
 * Forth processor top level
 * Serial in, outer interpreter, token queue, inner interpreter with
 * its data stack, serial out and the three LEDs
 */
`timescale 1ns/1ns

module forth_core (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	output logic led_r,
	output logic led_g,
	output logic led_b
);

	// Receiver to outer interpreter
	logic [7:0] rx_byte;
	logic rx_valid;
	logic rx_take;

	// Token path with credits
	logic tok_push;
	logic [forth_pkg::rom_addr_width-1:0] tok_xt;
	logic [3:0] tok_value;
	logic tok_credit;
	logic q_valid;
	logic q_pop;
	logic [forth_pkg::rom_addr_width-1:0] q_xt;
	logic [3:0] q_value;

	// Stack
	logic st_push;
	logic st_pop;
	logic st_write;
	logic [forth_pkg::cell_width-1:0] st_data;
	logic [forth_pkg::cell_width-1:0] st_top;
	logic [forth_pkg::cell_width-1:0] st_next;
	logic [forth_pkg::stack_ptr_width:0] st_depth;

	// Transmitter
	logic tx_start;
	logic [7:0] tx_byte;
	logic tx_busy;

	uart_rx uart_rx_i (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.rx_take(rx_take),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	outer_interp outer_interp_i (
		.clk(clk),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.rx_take(rx_take),
		.tok_push(tok_push),
		.tok_xt(tok_xt),
		.tok_value(tok_value),
		.tok_credit(tok_credit)
	);

	token_queue token_queue_i (
		.clk(clk),
		.reset(reset),
		.tok_push(tok_push),
		.tok_xt(tok_xt),
		.tok_value(tok_value),
		.q_pop(q_pop),
		.q_valid(q_valid),
		.q_xt(q_xt),
		.q_value(q_value),
		.tok_credit(tok_credit)
	);

	inner_interp inner_interp_i (
		.clk(clk),
		.reset(reset),
		.q_valid(q_valid),
		.q_xt(q_xt),
		.q_value(q_value),
		.q_pop(q_pop),
		.st_push(st_push),
		.st_pop(st_pop),
		.st_write(st_write),
		.st_data(st_data),
		.st_top(st_top),
		.st_next(st_next),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy),
		.led_r(led_r),
		.led_g(led_g),
		.led_b(led_b)
	);

	data_stack data_stack_i (
		.clk(clk),
		.reset(reset),
		.st_push(st_push),
		.st_pop(st_pop),
		.st_write(st_write),
		.st_data(st_data),
		.st_top(st_top),
		.st_next(st_next),
		.st_depth(st_depth)
	);

	uart_tx uart_tx_i (
		.clk(clk),
		.reset(reset),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx(tx),
		.tx_busy(tx_busy)
	);

endmodule

/* testbench/forth_checker.sv */
/*
 * Forth processor checker
 * Concurrent assertions on the token credits, queue pops, data
 * stack depth and the idle serial line, bound into the top level
 */
`timescale 1ns/1ns

module forth_checker (
	input  logic clk,
	input  logic reset,
	input  logic [forth_pkg::credit_width-1:0] credits,
	input  logic [forth_pkg::credit_width-1:0] q_count,
	input  logic tok_push,
	input  logic q_pop,
	input  logic q_valid,
	input  logic [forth_pkg::stack_ptr_width:0] st_depth,
	input  logic tx,
	input  logic tx_busy
);

	////////////////////////////////////////////////////////////////////////////
	// Token path
	////////////////////////////////////////////////////////////////////////////

	// Never more credits than queue entries
	credit_bound: assert property (@(posedge clk) disable iff (!reset)
		credits <= forth_pkg::credit_init)
		else $error("credit count above the queue depth");

	// A credit in hand means a free queue entry for the push
	push_credit: assert property (@(posedge clk) disable iff (!reset)
		tok_push |-> q_count < forth_pkg::queue_depth)
		else $error("token pushed into a full queue");

	// Inner interpreter pops only a present token
	pop_valid: assert property (@(posedge clk) disable iff (!reset)
		q_pop |-> q_valid)
		else $error("token queue popped while empty");

	////////////////////////////////////////////////////////////////////////////
	// Stack and serial line
	////////////////////////////////////////////////////////////////////////////

	// Underflow wraps the depth to a large value
	depth_bound: assert property (@(posedge clk) disable iff (!reset)
		st_depth <= (forth_pkg::stack_ptr_width + 1)'(forth_pkg::stack_depth))
		else $error("data stack depth out of range");

	// Line idles high between frames
	tx_idle: assert property (@(posedge clk) disable iff (!reset)
		!tx_busy |-> tx)
		else $error("tx low while the transmitter is idle");

endmodule

bind forth_core forth_checker checker_i (
	.clk(clk),
	.reset(reset),
	.credits(outer_interp_i.credits),
	.q_count(token_queue_i.count),
	.tok_push(tok_push),
	.q_pop(q_pop),
	.q_valid(q_valid),
	.st_depth(st_depth),
	.tx(tx),
	.tx_busy(tx_busy)
);

/* testbench/forth_tb.sv */
/*
 * Forth processor testbench
 * Types words on the serial input, decodes the serial output and
 * checks printed characters and LEDs against expected values
 */
`timescale 1ns/1ns

module forth_tb;

	localparam int clk_period = 4;
	localparam int bit_clks = forth_pkg::uart_clks_per_bit;
	// Characters typed and printed over the whole run
	localparam int chars_sent = 59;
	localparam int chars_expected = 8;
	// Twelve bit times per character, twice over
	localparam int timeout_ns = (chars_sent + chars_expected) * 12 * bit_clks * clk_period * 2;

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	logic led_r;
	logic led_g;
	logic led_b;

	string test_name;
	// Bytes still due on tx, oldest first
	logic [7:0] exp_q[$];
	int unsigned digits[6];
	int unsigned a;
	int unsigned b;
	int unsigned total;

	forth_core dut_i (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.tx(tx),
		.led_r(led_r),
		.led_g(led_g),
		.led_b(led_b)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic abort_run(input string what);
		$display("error in %s: %s", test_name, what);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic show_mismatch(input logic [7:0] expected, input logic [7:0] actual);
		$display("mismatch in %s: expected %02h, actual %02h", test_name, expected, actual);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [7:0] digit_char(input int unsigned n);
		return 8'h30 + 8'(n);
	endfunction

	// One frame LSB first, then two idle bit times
	task automatic send_char(input logic [7:0] c);
		rx = 1'b0;
		repeat (bit_clks) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rx = c[i];
			repeat (bit_clks) @(negedge clk);
		end
		rx = 1'b1;
		repeat (3 * bit_clks) @(negedge clk);
	endtask

	// Words of a line, closed by a carriage return
	task automatic send_line(input string s);
		for (int i = 0; i < s.len(); i++)
			send_char(s[i]);
		send_char(8'h0d);
	endtask

	task automatic wait_output();
		int limit;
		limit = (exp_q.size() + 2) * 12 * bit_clks;
		while (exp_q.size() != 0) begin
			if (limit == 0) begin
				abort_run("expected output did not appear on tx");
			end else begin
				limit--;
				@(negedge clk);
			end
		end
	endtask

	// LED pattern as {r, g, b}, low is on
	task automatic check_leds(input logic [2:0] expected);
		int limit;
		limit = 4 * bit_clks;
		while ({led_r, led_g, led_b} != expected && limit != 0) begin
			limit--;
			@(negedge clk);
		end
		assert ({led_r, led_g, led_b} == expected)
			else show_mismatch({5'd0, expected}, {5'd0, led_r, led_g, led_b});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Serial output decoder
	////////////////////////////////////////////////////////////////////////////
	initial begin : tx_decode
		logic [7:0] got;
		logic [7:0] expected;
		forever begin
			@(negedge clk);
			if (reset && !tx) begin
				// Move to the middle of the start bit
				repeat (bit_clks / 2 - 1) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (bit_clks) @(negedge clk);
					got[i] = tx;
				end
				repeat (bit_clks) @(negedge clk);
				assert (tx) else abort_run("stop bit missing on tx");
				if (exp_q.size() == 0) begin
					abort_run($sformatf("unexpected byte %02h on tx", got));
				end else begin
					expected = exp_q.pop_front();
					assert (got == expected) else show_mismatch(expected, got);
				end
			end
		end
	end

	initial begin
		#(timeout_ns);
		abort_run("watchdog expired before the tests finished");
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		rx = 1'b1;
		reset = 1'b0;
		test_name = "reset";
		void'($urandom(32'hcc79_a75e));
		repeat (2) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		check_leds(3'b111);
		assert (tx) else abort_run("tx low after reset");

		// Each colour word lights only its own LED
		test_name = "red";
		send_line("red");
		check_leds(3'b011);
		test_name = "green";
		send_line("green");
		check_leds(3'b101);
		test_name = "blue";
		send_line("blue");
		check_leds(3'b110);

		test_name = "add";
		a = $urandom % 10;
		b = $urandom % (10 - a);
		exp_q.push_back(digit_char(a + b));
		exp_q.push_back(8'h20);
		send_line($sformatf("%0d %0d + .", a, b));
		wait_output();

		// Smaller minus larger prints a sign
		test_name = "subtract";
		a = $urandom % 9;
		b = a + 1 + $urandom % (9 - a);
		exp_q.push_back(8'h2d);
		exp_q.push_back(digit_char(b - a));
		exp_q.push_back(8'h20);
		send_line($sformatf("%0d %0d - .", a, b));
		wait_output();

		test_name = "unknown word";
		exp_q.push_back(8'h3f);
		send_line("xyz");
		wait_output();

		// Twelve tokens, total kept to one digit
		test_name = "token stream";
		total = 0;
		for (int i = 0; i < 6; i++) begin
			digits[i] = $urandom % (10 - total);
			total += digits[i];
		end
		exp_q.push_back(digit_char(total));
		exp_q.push_back(8'h20);
		send_line($sformatf("%0d %0d %0d %0d %0d %0d + + + + + .", digits[0], digits[1],
			digits[2], digits[3], digits[4], digits[5]));
		wait_output();

		// One frame of quiet line
		test_name = "idle after run";
		repeat (12 * bit_clks) begin
			@(negedge clk);
			assert (tx) else abort_run("tx active with no output expected");
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

/* vlog.f */
logic/forth_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/outer_interp.sv
logic/token_queue.sv
logic/data_stack.sv
logic/inner_interp.sv
logic/forth_core.sv
testbench/forth_checker.sv
testbench/forth_tb.sv

/* Makefile */
# Verilator build and run of the Forth processor testbench

VERILATOR ?= verilator
TOP ?= forth_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG ?= Simulation failed
PASS_MSG ?= Simulation passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)

test: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED, run ended early"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
